// ==== compile.f ====
verilog/wb_pkg.sv
verilog/ram_port_if.sv
verilog/lzp.sv
verilog/dirty_block.sv
verilog/line_ram.sv
verilog/ram_arbiter.sv
verilog/host_port.sv
verilog/writeback_engine.sv
verilog/wb_buffer_top.sv
dv/wb_buffer_tb.sv

// ==== dv/wb_buffer_tb.sv ====
/*
 * Testbench for the write-back staging buffer.
 * Applies a table of stores, loads and flushes, checks against a reference model.
 */

`timescale 1ns/10ps
`default_nettype none

module wb_buffer_tb import wb_pkg::*; ();

	localparam int DP = 8;                          // Dirty set depth under test.
	localparam int LINES = 2 ** LINE_AW;            // Lines in the local copy.
	localparam int FLUSH_WAIT = DP * 4 * 3;         // Longest drain we allow.
	localparam int MARGIN = 100;                    // Spare cycles on top of the estimate.

	typedef enum logic [1:0] {OP_IDLE, OP_STORE, OP_LOAD, OP_FLUSH} op_e;

	typedef struct {
		op_e op;                                    // What the row does.
		word_addr_u addr;                           // Word address for stores and loads.
		word_t data;                                // Store data.
		logic exp_err;                              // Store is expected to be refused.
	} row_t;

	logic CLK = 1'b0;
	logic rst_i;
	logic st_valid_i;
	word_addr_u st_addr_i;
	word_t st_data_i;
	logic ld_valid_i;
	word_addr_u ld_addr_i;
	logic st_err_o;
	logic ld_valid_o;
	word_t ld_data_o;
	logic flush_i;
	logic wb_valid_o;
	word_addr_u wb_addr_o;
	word_t wb_data_o;
	logic flush_done_o;
	logic dirty_full_o;

	row_t table_q [$];                              // Stimulus and expected refusals.
	logic [LINES-1:0] build_dirty;                  // Dirty lines while the table is built.
	word_t shadow_mem [2 ** WORD_AW];               // Expected RAM contents.
	logic [LINES-1:0] shadow_dirty;                 // Expected dirty set.
	logic [LINES-1:0] flush_set;                    // Lines the running flush must drain.
	int words_seen [LINES];                         // Words written back per line.
	word_t exp_ld [$];                              // Load results due next cycle.
	logic err_due;                                  // Refusal due next cycle.
	logic flush_active;
	int val_errs = 0;
	int proto_errs = 0;
	int cycles = 0;
	int cycle_limit;
	int seed = 6284;

	always #5 CLK = ~CLK;                           // 10 ns clock.

	wb_buffer_top #(.DP(DP)) u_dut (
		.CLK          (CLK),
		.rst_i        (rst_i),
		.st_valid_i   (st_valid_i),
		.st_addr_i    (st_addr_i),
		.st_data_i    (st_data_i),
		.ld_valid_i   (ld_valid_i),
		.ld_addr_i    (ld_addr_i),
		.st_err_o     (st_err_o),
		.ld_valid_o   (ld_valid_o),
		.ld_data_o    (ld_data_o),
		.flush_i      (flush_i),
		.wb_valid_o   (wb_valid_o),
		.wb_addr_o    (wb_addr_o),
		.wb_data_o    (wb_data_o),
		.flush_done_o (flush_done_o),
		.dirty_full_o (dirty_full_o)
	);

	// Cycle counter that ends a run which never reaches its end.
	always @(negedge CLK) begin
		if (!rst_i) begin
			cycles++;
			if (cycles >= cycle_limit) begin
				$display("Timeout: test still running after %0d cycles", cycles);
				$display("Errors: %0d value, %0d protocol", val_errs, proto_errs);
				$display("Simulation finished: FAIL");
				$finish;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks and helpers
	//////////////////////////////////////////////////////////////////////

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			val_errs++;
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input string what, input word_addr_u got, input word_addr_u exp);
		if (got !== exp) begin
			val_errs++;
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got.flat, exp.flat);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			val_errs++;
			$display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	function automatic word_addr_u make_addr(input int line, input int word);
		word_addr_u a;
		a.lw.line = line_addr_t'(line);
		a.lw.word = WORD_OW'(word);
		return a;
	endfunction

	// Builds one row; a store to a new line is refused once DP lines are dirty.
	task automatic add_row(input op_e op, input int line, input int word);
		row_t row;
		row.op = op;
		row.addr = make_addr(line, word);
		row.data = '0;
		row.exp_err = 1'b0;
		if (op == OP_STORE) begin
			row.data = word_t'($random(seed));
			row.exp_err = !build_dirty[line] && ($countones(build_dirty) >= DP);
			if (!row.exp_err) begin
				build_dirty[line] = 1'b1;
			end
		end else if (op == OP_FLUSH) begin
			build_dirty = '0;                       // A flush empties the set.
		end
		table_q.push_back(row);
	endtask

	task automatic build_table();
		build_dirty = '0;
		add_row(OP_LOAD, 5, 1);                     // Never stored, reads zero.
		add_row(OP_LOAD, 63, 3);
		for (int rep = 0; rep < 5; rep++) begin
			for (int i = 0; i < DP; i++) begin
				add_row(OP_STORE, i * 5 + 2, (i + rep) % 4); // Lines merge on repeats.
			end
		end
		for (int i = 0; i < DP; i++) begin
			add_row(OP_LOAD, i * 5 + 2, i % 4);
			add_row(OP_LOAD, i * 5 + 2, (i + 2) % 4);
		end
		add_row(OP_STORE, 50, 1);                   // Set is full, new line refused.
		add_row(OP_IDLE, 0, 0);
		add_row(OP_LOAD, 50, 1);                    // Old value, still zero.
		add_row(OP_STORE, 51, 2);
		add_row(OP_STORE, 2, 3);                    // Present line, accepted while full.
		add_row(OP_FLUSH, 0, 0);
		for (int i = 0; i < 6; i++) begin
			add_row(OP_LOAD, i * 5 + 2, (i + 1) % 4); // Host loads cut into the drain.
			add_row(OP_IDLE, 0, 0);
		end
		for (int i = 0; i < 4; i++) begin
			add_row(OP_IDLE, 0, 0);
		end
		add_row(OP_FLUSH, 0, 0);                    // Empty set, no write-back.
		for (int i = 0; i < DP; i++) begin
			add_row(OP_STORE, 60 - i, i % 4);
		end
		add_row(OP_STORE, 60, 2);
		add_row(OP_STORE, 9, 0);
		add_row(OP_LOAD, 9, 0);
		add_row(OP_LOAD, 60, 2);
		add_row(OP_FLUSH, 0, 0);
	endtask

	task automatic clear_inputs();
		st_valid_i = 1'b0;
		ld_valid_i = 1'b0;
		flush_i = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Output checking, once per falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic take_writeback();
		line_addr_t line;
		word_addr_u exp_addr;
		line = wb_addr_o.lw.line;
		if (!flush_active) begin
			proto_errs++;
			$display("%0t: write-back word at %h while no flush was running", $time, wb_addr_o.flat);
		end else if (!flush_set[line]) begin
			proto_errs++;
			$display("%0t: write-back of line %0d, which is not dirty", $time, line);
		end else if (words_seen[line] >= 4) begin
			proto_errs++;
			$display("%0t: line %0d written back more than once", $time, line);
		end else begin
			exp_addr = make_addr(int'(line), words_seen[line]); // Words leave in order.
			check_addr("wb_addr_o", wb_addr_o, exp_addr);
			check_word("wb_data_o", wb_data_o, shadow_mem[exp_addr.flat]);
			words_seen[line]++;
		end
	endtask

	task automatic close_flush();
		if (!flush_active) begin
			check_flag("flush_done_o", flush_done_o, 1'b0); // Second pulse or stray pulse.
		end else begin
			for (int l = 0; l < LINES; l++) begin
				if (flush_set[l] && words_seen[l] != 4) begin
					proto_errs++;
					$display("%0t: flush ended with line %0d at %0d of 4 words", $time, l,
						words_seen[l]);
				end
			end
			flush_active = 1'b0;
		end
	endtask

	task automatic next_cycle();
		word_t exp_data;
		@(negedge CLK);
		check_flag("st_err_o", st_err_o, err_due);
		err_due = 1'b0;
		check_flag("ld_valid_o", ld_valid_o, exp_ld.size() > 0);
		if (exp_ld.size() > 0) begin
			exp_data = exp_ld.pop_front();
			if (ld_valid_o) begin
				check_word("ld_data_o", ld_data_o, exp_data);
			end
		end
		if (wb_valid_o) begin
			take_writeback();
		end
		if (flush_done_o) begin
			close_flush();
		end
		if (!flush_active) begin
			check_flag("dirty_full_o", dirty_full_o, $countones(shadow_dirty) == DP);
		end
	endtask

	task automatic wait_flush_done();
		int n;
		n = 0;
		while (flush_active && n < FLUSH_WAIT) begin
			next_cycle();
			clear_inputs();
			n++;
		end
		if (flush_active) begin
			proto_errs++;
			$display("%0t: flush_done_o did not arrive within %0d cycles", $time, FLUSH_WAIT);
			flush_active = 1'b0;
		end
	endtask

	// Drives one row and records what the DUT owes us in the next cycle.
	task automatic apply_row(input row_t row);
		clear_inputs();
		case (row.op)
			OP_STORE: begin
				st_valid_i = 1'b1;
				st_addr_i = row.addr;
				st_data_i = row.data;
				err_due = row.exp_err;
				if (!row.exp_err) begin
					shadow_mem[row.addr.flat] = row.data;
					shadow_dirty[row.addr.lw.line] = 1'b1;
				end
			end
			OP_LOAD: begin
				ld_valid_i = 1'b1;
				ld_addr_i = row.addr;
				exp_ld.push_back(shadow_mem[row.addr.flat]); // Value before this cycle.
			end
			OP_FLUSH: begin
				flush_i = 1'b1;
				flush_active = 1'b1;
				flush_set = shadow_dirty;           // Everything dirty must come out.
				shadow_dirty = '0;
				for (int l = 0; l < LINES; l++) begin
					words_seen[l] = 0;
				end
			end
			default: begin
			end
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		rst_i = 1'b1;
		clear_inputs();
		st_addr_i = '0;
		st_data_i = '0;
		ld_addr_i = '0;
		err_due = 1'b0;
		flush_active = 1'b0;
		shadow_dirty = '0;
		flush_set = '0;
		for (int i = 0; i < 2 ** WORD_AW; i++) begin
			shadow_mem[i] = '0;
		end
		for (int l = 0; l < LINES; l++) begin
			words_seen[l] = 0;
		end
		build_table();
		cycle_limit = table_q.size() * 2 + DP * 4 * 3 + MARGIN;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		rst_i = 1'b0;
		for (int r = 0; r < table_q.size(); r++) begin
			if (table_q[r].op == OP_STORE || table_q[r].op == OP_FLUSH) begin
				wait_flush_done();                  // No store or flush during a drain.
			end
			next_cycle();
			apply_row(table_q[r]);
		end
		wait_flush_done();
		next_cycle();
		clear_inputs();
		next_cycle();
		$display("Errors: %0d value, %0d protocol", val_errs, proto_errs);
		if (val_errs == 0 && proto_errs == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build the write-back buffer testbench with Verilator and run it.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module wb_buffer_tb -f compile.f -o wb_buffer_sim

./obj_dir/wb_buffer_sim | tee sim.log

# The testbench prints its verdict last; look for a failure in the log.
if grep -q "Simulation finished: FAIL" sim.log; then
	echo "Testbench reported a failure, see sim.log"
	exit 1
fi
echo "Run complete, log in sim.log"

// ==== verilog/dirty_block.sv ====
/*
 * Dirty line address set without duplicates.
 * New lines fill the lowest free slot, pops drain the lowest valid slot.
 */

`timescale 1ns/10ps
`default_nettype none

module dirty_block import wb_pkg::*; #(
	parameter int DP = 8                          // Number of slots.
) (
	input  logic CLK,
	input  logic rst_i,
	input  logic push_i,                          // Record a line as dirty.
	input  line_addr_t addr_i,                    // Line to record.
	output logic accept_o,                        // Line present or a slot free.
	input  logic pop_i,                           // Drop the head line.
	output line_addr_t addr_o,                    // Head line address.
	output logic empty_o,                         // No line is dirty.
	output logic full_o                           // Every slot is taken.
);

	localparam int SW = (DP > 1) ? $clog2(DP) : 1; // Slot index width.

	logic [DP-1:0] valid_q;                       // Slot holds a dirty line.
	line_addr_t slot_addr [DP];                   // Line address per slot.
	logic [DP-1:0] match;                         // Incoming line equals a valid slot.
	logic hit;                                    // Line is already recorded.
	logic [SW-1:0] free_pos;                      // Lowest free slot.
	logic no_free;                                // All slots are valid.
	logic [SW-1:0] head_pos;                      // Lowest valid slot.
	logic no_head;                                // No slot is valid.
	logic insert;                                 // Push of a new line into a free slot.

	//////////////////////////////////////////////////////////////////////
	// Slot search
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < DP; i++) begin
			match[i] = valid_q[i] && (slot_addr[i] == addr_i); // Only valid slots count.
		end
	end

	assign hit = |match;                          // Merge instead of storing twice.

	lzp #(.CW(DP)) u_free_lzp (
		.in_i   (~valid_q),                       // Free slots are the cleared bits.
		.pos_o  (free_pos),
		.all0_o (no_free)
	);

	lzp #(.CW(DP)) u_head_lzp (
		.in_i   (valid_q),                        // The head is the lowest valid slot.
		.pos_o  (head_pos),
		.all0_o (no_head)
	);

	assign accept_o = hit || !no_free;            // A store may proceed.
	assign insert = push_i && !hit && !no_free;   // Only new lines take a slot.
	assign addr_o = slot_addr[head_pos];          // Head address for the drain.
	assign empty_o = no_head;
	assign full_o = no_free;

	//////////////////////////////////////////////////////////////////////
	// Slot update
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst_i) begin
			valid_q <= '0;                        // Set starts empty.
		end else begin
			if (pop_i) begin
				valid_q[head_pos] <= 1'b0;        // Retire the drained line.
			end
			if (insert) begin
				valid_q[free_pos] <= 1'b1;        // Free slot differs from the head slot.
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (insert) begin
			slot_addr[free_pos] <= addr_i;        // Address is only meaningful while valid.
		end
	end

	// The drain must only pop what is there.
	a_no_pop_empty: assert property (@(posedge CLK) disable iff (rst_i)
		pop_i |-> !empty_o)
		else $error("dirty_block: pop while the set is empty");

	// The host port must hold back any store the set refused.
	a_no_push_refused: assert property (@(posedge CLK) disable iff (rst_i)
		push_i |-> accept_o)
		else $error("dirty_block: push while accept is low");

endmodule

`default_nettype wire

// ==== verilog/host_port.sv ====
/*
 * Host side of the buffer.
 * Turns store and load strobes into RAM accesses and marks lines dirty.
 */

`timescale 1ns/10ps
`default_nettype none

module host_port import wb_pkg::*; (
	input  logic CLK,
	input  logic rst_i,
	input  logic st_valid_i,          // Store strobe.
	input  word_addr_u st_addr_i,     // Store word address.
	input  word_t st_data_i,          // Store data.
	input  logic ld_valid_i,          // Load strobe.
	input  word_addr_u ld_addr_i,     // Load word address.
	output logic st_err_o,            // Store was refused, one cycle late.
	output logic ld_valid_o,          // Load data is valid.
	output word_t ld_data_o,          // Load data.
	ram_port_if.master ram,           // Request to the shared RAM.
	output logic dirty_push_o,        // Record the stored line.
	output line_addr_t dirty_addr_o,  // Line of the store.
	input  logic dirty_accept_i       // Dirty set can take the line.
);

	logic st_ok;                      // Store goes ahead.

	assign st_ok = st_valid_i && dirty_accept_i;  // A refused store leaves the RAM alone.

	// One request per strobe, stores write and loads read.
	assign ram.req = st_ok || ld_valid_i;
	assign ram.we = st_ok;
	assign ram.addr = st_valid_i ? st_addr_i : ld_addr_i;
	assign ram.wdata = st_data_i;

	assign dirty_push_o = st_ok;                  // Same cycle as the RAM write.
	assign dirty_addr_o = st_addr_i.lw.line;      // Line field of the word address.

	always_ff @(posedge CLK) begin
		if (rst_i) begin
			st_err_o <= 1'b0;
			ld_valid_o <= 1'b0;
		end else begin
			st_err_o <= st_valid_i && !dirty_accept_i;  // Report the refusal.
			ld_valid_o <= ld_valid_i && ram.gnt;        // Matches the registered read.
		end
	end

	assign ld_data_o = ram.rdata;                 // RAM output already lags by one cycle.

	a_no_st_ld: assert property (@(posedge CLK) disable iff (rst_i)
		!(st_valid_i && ld_valid_i))
		else $error("host_port: store and load in the same cycle");

endmodule

`default_nettype wire

// ==== verilog/line_ram.sv ====
/*
 * Single-port word RAM holding the local copy of all lines.
 * Registered read, old data returned on a same-address write.
 */

`timescale 1ns/10ps
`default_nettype none

module line_ram import wb_pkg::*; (
	input  logic CLK,
	input  logic we_i,            // Write strobe.
	input  word_addr_u addr_i,    // Word address, flat view.
	input  word_t wdata_i,        // Data to write.
	output word_t rdata_o         // Read data one cycle later.
);

	localparam int DEPTH = 2 ** WORD_AW;  // 256 words.

	word_t mem [DEPTH];                   // Storage array.

	// Local copy begins cleared.
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	// Read is taken before the write lands, so a write returns the old word.
	always @(posedge CLK) begin
		rdata_o <= mem[addr_i.flat];          // Registered read every cycle.
		if (we_i) begin
			mem[addr_i.flat] <= wdata_i;      // Write at the end of the cycle.
		end
	end

endmodule

`default_nettype wire

// ==== verilog/lzp.sv ====
/*
 * Priority encoder giving the position of the lowest set bit.
 * Used to pick free and valid slots of the dirty set.
 */

`timescale 1ns/10ps
`default_nettype none

module lzp #(
	parameter int CW = 8,                        // Width of the input vector.
	localparam int PW = (CW > 1) ? $clog2(CW) : 1  // Width of the position.
) (
	input  logic [CW-1:0] in_i,   // Bits to search.
	output logic [PW-1:0] pos_o,  // Index of the lowest set bit.
	output logic all0_o           // No bit set at all.
);

	// Scan from the top down so that the lowest set bit is written last.
	always_comb begin
		pos_o = '0;                               // Position zero when nothing is set.
		for (int i = CW - 1; i >= 0; i--) begin
			if (in_i[i]) begin
				pos_o = PW'(i);                   // Lower hits override higher ones.
			end
		end
	end

	assign all0_o = ~|in_i;                       // Empty input flag.

endmodule

`default_nettype wire

// ==== verilog/ram_arbiter.sv ====
/*
 * Fixed-priority arbiter for the shared line RAM.
 * The host always wins, the write-back engine takes idle cycles.
 */

`timescale 1ns/10ps
`default_nettype none

module ram_arbiter import wb_pkg::*; (
	input logic CLK,
	input logic rst_i,
	ram_port_if.arbiter host_port,    // High-priority master.
	ram_port_if.arbiter wb_port       // Low-priority master.
);

	logic ram_we;                     // Write strobe to the RAM.
	word_addr_u ram_addr;             // Address of the granted master.
	word_t ram_wdata;                 // Write data of the granted master.
	word_t ram_rdata;                 // Registered read data.

	//////////////////////////////////////////////////////////////////////
	// Grant and request mux
	//////////////////////////////////////////////////////////////////////

	assign host_port.gnt = host_port.req;                    // Host is never held off.
	assign wb_port.gnt = wb_port.req && !host_port.req;      // Drain uses idle cycles.

	always_comb begin
		if (host_port.req) begin
			ram_we = host_port.we;                           // Host access this cycle.
			ram_addr = host_port.addr;
			ram_wdata = host_port.wdata;
		end else begin
			ram_we = wb_port.gnt && wb_port.we;              // No write without a grant.
			ram_addr = wb_port.addr;
			ram_wdata = wb_port.wdata;
		end
	end

	line_ram u_line_ram (
		.CLK     (CLK),
		.we_i    (ram_we),
		.addr_i  (ram_addr),
		.wdata_i (ram_wdata),
		.rdata_o (ram_rdata)
	);

	// Each master knows from its own grant whether the data is its own.
	assign host_port.rdata = ram_rdata;
	assign wb_port.rdata = ram_rdata;

	// A drain read that the host held off is asked for again until it is granted.
	a_wb_req_held: assert property (@(posedge CLK) disable iff (rst_i)
		wb_port.req && !wb_port.gnt |=> wb_port.req)
		else $error("ram_arbiter: write-back request dropped before its grant");

endmodule

`default_nettype wire

// ==== verilog/ram_port_if.sv ====
/*
 * Request bundle from one master to the shared line RAM.
 */

`timescale 1ns/10ps
`default_nettype none

interface ram_port_if import wb_pkg::*; ();

	logic req;          // Master asks for the RAM this cycle.
	logic we;           // Write when high, read when low.
	word_addr_u addr;   // Word address of the access.
	word_t wdata;       // Write data.
	word_t rdata;       // Read data, one cycle after a granted read.
	logic gnt;          // Same-cycle grant from the arbiter.

	// The master owns the request side.
	modport master (output req, output we, output addr, output wdata,
		input rdata, input gnt);

	// The arbiter sees the request and answers with grant and data.
	modport arbiter (input req, input we, input addr, input wdata,
		output rdata, output gnt);

endinterface

`default_nettype wire

// ==== verilog/wb_buffer_top.sv ====
/*
 * Write-back staging buffer top level.
 * Host port and write-back engine share one line RAM.
 */

`timescale 1ns/10ps
`default_nettype none

module wb_buffer_top import wb_pkg::*; #(
	parameter int DP = 8                  // Dirty set depth.
) (
	input  logic CLK,
	input  logic rst_i,
	input  logic st_valid_i,              // Store strobe.
	input  word_addr_u st_addr_i,
	input  word_t st_data_i,
	input  logic ld_valid_i,              // Load strobe.
	input  word_addr_u ld_addr_i,
	output logic st_err_o,                // Refused store.
	output logic ld_valid_o,
	output word_t ld_data_o,
	input  logic flush_i,                 // Drain request.
	output logic wb_valid_o,              // Write-back word strobe.
	output word_addr_u wb_addr_o,
	output word_t wb_data_o,
	output logic flush_done_o,            // Drain finished.
	output logic dirty_full_o             // Every dirty slot is taken.
);

	ram_port_if host_ram ();              // Host to arbiter.
	ram_port_if wb_ram ();                // Engine to arbiter.

	logic dirty_push;
	line_addr_t dirty_push_addr;
	logic dirty_accept;
	logic dirty_pop;
	line_addr_t dirty_head;
	logic dirty_empty;

	host_port u_host_port (
		.CLK            (CLK),
		.rst_i          (rst_i),
		.st_valid_i     (st_valid_i),
		.st_addr_i      (st_addr_i),
		.st_data_i      (st_data_i),
		.ld_valid_i     (ld_valid_i),
		.ld_addr_i      (ld_addr_i),
		.st_err_o       (st_err_o),
		.ld_valid_o     (ld_valid_o),
		.ld_data_o      (ld_data_o),
		.ram            (host_ram.master),
		.dirty_push_o   (dirty_push),
		.dirty_addr_o   (dirty_push_addr),
		.dirty_accept_i (dirty_accept)
	);

	writeback_engine u_writeback_engine (
		.CLK           (CLK),
		.rst_i         (rst_i),
		.flush_i       (flush_i),
		.ram           (wb_ram.master),
		.dirty_addr_i  (dirty_head),
		.dirty_empty_i (dirty_empty),
		.dirty_pop_o   (dirty_pop),
		.wb_valid_o    (wb_valid_o),
		.wb_addr_o     (wb_addr_o),
		.wb_data_o     (wb_data_o),
		.flush_done_o  (flush_done_o)
	);

	dirty_block #(.DP(DP)) u_dirty_block (
		.CLK      (CLK),
		.rst_i    (rst_i),
		.push_i   (dirty_push),
		.addr_i   (dirty_push_addr),
		.accept_o (dirty_accept),
		.pop_i    (dirty_pop),
		.addr_o   (dirty_head),
		.empty_o  (dirty_empty),
		.full_o   (dirty_full_o)
	);

	ram_arbiter u_ram_arbiter (
		.CLK       (CLK),
		.rst_i     (rst_i),
		.host_port (host_ram.arbiter),
		.wb_port   (wb_ram.arbiter)
	);

endmodule

`default_nettype wire

// ==== verilog/wb_pkg.sv ====
/*
 * Write-back staging buffer shared definitions.
 * Address widths, the data word and the dual-view word address.
 */

`default_nettype none

package wb_pkg;

	//////////////////////////////////////////////////////////////////////
	// Address geometry
	//////////////////////////////////////////////////////////////////////

	localparam int LINE_AW = 6;                 // 64 lines in the local copy.
	localparam int WORD_OW = 2;                 // 4 words in every line.
	localparam int WORD_AW = LINE_AW + WORD_OW; // Flat word address, 256 words.

	typedef logic [31:0] word_t;                // One data word.
	typedef logic [LINE_AW-1:0] line_addr_t;    // Line address as kept in the dirty set.

	// Line and word fields of a word address, line in the upper bits.
	typedef struct packed {
		line_addr_t line;                       // Selects the line.
		logic [WORD_OW-1:0] word;               // Selects the word inside the line.
	} line_word_t;

	// The RAM indexes by the flat view; the dirty logic reads the split view.
	typedef union packed {
		logic [WORD_AW-1:0] flat;               // Flat word index into the line RAM.
		line_word_t lw;                         // Line and word pair.
	} word_addr_u;

endpackage

`default_nettype wire

// ==== verilog/writeback_engine.sv ====
/*
 * Write-back engine.
 * On flush, reads every dirty line word by word and sends it out.
 */

`timescale 1ns/10ps
`default_nettype none

module writeback_engine import wb_pkg::*; (
	input  logic CLK,
	input  logic rst_i,
	input  logic flush_i,             // Start a drain.
	ram_port_if.master ram,           // Read requests to the shared RAM.
	input  line_addr_t dirty_addr_i,  // Head line of the dirty set.
	input  logic dirty_empty_i,       // No line left to drain.
	output logic dirty_pop_o,         // Retire the head line.
	output logic wb_valid_o,          // Write-back word strobe.
	output word_addr_u wb_addr_o,     // Write-back word address.
	output word_t wb_data_o,          // Write-back word data.
	output logic flush_done_o         // Drain finished.
);

	typedef enum logic [1:0] {
		S_IDLE,                       // Waiting for a flush.
		S_READING,                    // Issuing reads of dirty lines.
		S_DRAINING                    // Waiting for the last word to return.
	} state_t;

	state_t state_q;
	state_t state_d;
	logic [WORD_OW-1:0] word_cnt_q;   // Next word of the head line.
	word_addr_u rd_addr;              // Address of the current read.
	logic rd_fire;                    // Read granted this cycle.
	logic pend_valid_q;               // A read returns this cycle.
	word_addr_u pend_addr_q;          // Address of the returning read.

	//////////////////////////////////////////////////////////////////////
	// Read issue
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		rd_addr.lw.line = dirty_addr_i;           // Head line.
		rd_addr.lw.word = word_cnt_q;             // Word counter picks the word.
	end

	assign ram.req = (state_q == S_READING) && !dirty_empty_i;  // Held until granted.
	assign ram.we = 1'b0;                         // The drain only reads.
	assign ram.addr = rd_addr;
	assign ram.wdata = '0;
	assign rd_fire = ram.req && ram.gnt;
	assign dirty_pop_o = rd_fire && (&word_cnt_q); // Last word of the line granted.

	//////////////////////////////////////////////////////////////////////
	// State machine
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: begin
				if (flush_i) begin
					state_d = S_READING;          // Flushes are only taken here.
				end
			end
			S_READING: begin
				if (dirty_empty_i) begin
					state_d = S_DRAINING;         // Nothing left to read.
				end
			end
			S_DRAINING: begin
				if (!pend_valid_q) begin
					state_d = S_IDLE;             // Last word has gone out.
				end
			end
			default: state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst_i) begin
			state_q <= S_IDLE;
			word_cnt_q <= '0;
			pend_valid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (rd_fire) begin
				word_cnt_q <= word_cnt_q + WORD_OW'(1); // Wraps to zero after the fourth word.
			end
			pend_valid_q <= rd_fire;              // One read in flight per grant.
		end
	end

	// Return register pairs the address with the data a cycle later.
	always_ff @(posedge CLK) begin
		if (rd_fire) begin
			pend_addr_q <= rd_addr;
		end
	end

	assign wb_valid_o = pend_valid_q;
	assign wb_addr_o = pend_addr_q;
	assign wb_data_o = ram.rdata;                 // Registered RAM output.
	assign flush_done_o = (state_q == S_DRAINING) && !pend_valid_q; // Single pulse.

endmodule

`default_nettype wire
